// ==== multibank_mem.f ====
+incdir+tests
source/mbank_pkg.sv
source/bram_bank.sv
source/bank_translator.sv
source/multibank_mem.sv
tests/multibank_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

sim_out=$(
  verilator --binary --timing \
    -f multibank_mem.f \
    --top-module multibank_mem_tb \
    -Mdir obj_dir \
    -o multibank_mem_sim 2>&1 \
  && ./obj_dir/multibank_mem_sim 2>&1
)

echo "$sim_out"

echo "$sim_out" | grep -qx "Simulation PASSED" \
  && exit 0 \
  || exit 1

// ==== tests/mbank_checks.svh ====
`ifndef MBANK_CHECKS_SVH
`define MBANK_CHECKS_SVH

// opens a test, clears its error count
task automatic start_test(input string name);
  cur_test  = name;
  test_errs = 0;
endtask

// one line per test, then the tally
task automatic finish_test();
  if (test_errs == 0) begin
    $display("test %s: ok", cur_test);
    tests_passed++;
  end else begin
    $display("test %s: %0d errors", cur_test, test_errs);
    tests_failed++;
  end
endtask

// single write strobe, returns at the next drive point
task automatic host_write(input haddr_t addr, input hword_t din, input hstrb_t strb);
  req        = '0;
  req.wren   = 1'b1;
  req.wrstrb = strb;
  req.addr   = addr;
  req.din    = din;
  // reference copy, a set strobe bit replaces its byte
  for (int k = 0; k < mbank_pkg::HOST_STRB_W; k++) begin
    if (strb[k]) begin
      model[addr][k*8 +: 8] = din[k*8 +: 8];
    end
  end
  @(posedge clk);
  #1;
  req = '0;  // idle unless the caller drives again right away
endtask

// single read strobe, sampled at the next edge
task automatic host_read(input haddr_t addr);
  req      = '0;
  req.rden = 1'b1;
  req.addr = addr;
  @(posedge clk);
  #1;
  req = '0;
endtask

// counts edges from the read strobe edge until dack_o shows up
task automatic wait_dack(output int edges);
  edges = 1;  // the strobe edge is already behind us
  while (!dack && edges <= DACK_TIMEOUT) begin
    @(posedge clk);
    #1;
    edges++;
  end
  if (!dack) begin
    $display("test %s: no read acknowledge within %0d cycles", cur_test, DACK_TIMEOUT);
    test_errs++;
  end
endtask

task automatic check_word(input string what, input hword_t exp, input hword_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    test_errs++;
  end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %b, actual %b", cur_test, what, exp, act);
    test_errs++;
  end
endtask

// latency in edges between strobe and acknowledge
task automatic check_latency(input string what, input int exp, input int act);
  if (act != exp) begin
    $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    test_errs++;
  end
endtask

`endif

// ==== tests/multibank_mem_tb.sv ====
`timescale 1ns/1ps

module multibank_mem_tb;

  localparam int RD_LAT       = 2;   // two reads can be in flight
  localparam int DACK_TIMEOUT = 20;  // cycles
  localparam int HOST_WORDS   = 1 << mbank_pkg::HOST_ADDR_W;
  localparam int B2B_READS    = 16;

  typedef logic [mbank_pkg::HOST_ADDR_W-1:0] haddr_t;
  typedef logic [mbank_pkg::HOST_DATA_W-1:0] hword_t;
  typedef logic [mbank_pkg::HOST_STRB_W-1:0] hstrb_t;

  logic                 clk;
  logic                 rst_i;
  mbank_pkg::host_req_t req;    // host request into the DUT
  hword_t               rdata;
  logic                 dack;

  // expected memory, host word view
  hword_t model [HOST_WORDS];

  string cur_test;
  int    test_errs;
  int    tests_passed;
  int    tests_failed;

  multibank_mem #(
    .RD_LATENCY (RD_LAT)
  ) i_multibank_mem (
    .clk     (clk),
    .rst_i   (rst_i),
    .req_i   (req),
    .rdata_o (rdata),
    .dack_o  (dack)
  );

  always #5 clk = ~clk;  // 10 ns period

  `include "mbank_checks.svh"

  // distinct per address, both lanes differ too
  function automatic hword_t fill_pattern(input haddr_t a);
    return {7'h35, a, 7'h4B, ~a};
  endfunction

  // read, wait for the ack, compare, then make sure the ack was one pulse
  task automatic read_and_check(input haddr_t addr);
    int edges;
    host_read(addr);
    wait_dack(edges);
    check_latency("read latency", RD_LAT, edges);
    check_word($sformatf("rdata @%h", addr), model[addr], rdata);
    @(posedge clk);
    #1;
    check_flag("dack one cycle only", 1'b0, dack);
  endtask

  // nothing driven, nothing acknowledged
  task automatic reset_idle();
    start_test("reset_idle");
    for (int c = 0; c < 10; c++) begin
      check_flag($sformatf("dack idle cycle %0d", c), 1'b0, dack);
      @(posedge clk);
      #1;
    end
    finish_test();
  endtask

  task automatic full_word();
    haddr_t addrs [8];
    start_test("full_word");
    foreach (addrs[i]) begin
      addrs[i] = haddr_t'($urandom);
      host_write(addrs[i], hword_t'($urandom), '1);
    end
    foreach (addrs[i]) begin
      read_and_check(addrs[i]);
    end
    finish_test();
  endtask

  // single bytes first, then mixes
  task automatic byte_strobe();
    hstrb_t patterns [14] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h5, 4'h6,
                              4'h9, 4'hA, 4'hC, 4'h7, 4'hB, 4'hD, 4'hE};
    haddr_t addr;
    start_test("byte_strobe");
    for (int side = 0; side < 2; side++) begin
      addr    = haddr_t'($urandom);
      addr[0] = (side == 1);  // even word hits banks 0/1, odd word banks 2/3
      host_write(addr, hword_t'($urandom), '1);
      read_and_check(addr);
      foreach (patterns[p]) begin
        host_write(addr, hword_t'($urandom), patterns[p]);
        read_and_check(addr);  // clear strobes keep the old bytes
      end
    end
    finish_test();
  endtask

  // a lane collision would overwrite some earlier word
  task automatic bank_mapping();
    start_test("bank_mapping");
    for (int a = 0; a < HOST_WORDS; a++) begin
      host_write(haddr_t'(a), fill_pattern(haddr_t'(a)), '1);
    end
    for (int a = 0; a < HOST_WORDS; a++) begin
      read_and_check(haddr_t'(a));
    end
    finish_test();
  endtask

  // strobes every cycle, acks expected on a fixed schedule
  task automatic back_to_back();
    haddr_t addrs [B2B_READS];
    logic   exp_ack;
    start_test("back_to_back");
    foreach (addrs[i]) begin
      addrs[i] = haddr_t'($urandom);
    end
    for (int c = 0; c < B2B_READS + RD_LAT + 2; c++) begin
      exp_ack = (c >= RD_LAT) && (c < B2B_READS + RD_LAT);  // read i acks in cycle i + RD_LAT
      check_flag($sformatf("dack in cycle %0d", c), exp_ack, dack);
      if (exp_ack) begin
        check_word($sformatf("rdata of read %0d", c - RD_LAT),
                   model[addrs[c - RD_LAT]], rdata);
      end
      if (c < B2B_READS) begin
        host_read(addrs[c]);
      end else begin
        @(posedge clk);
        #1;
      end
    end
    finish_test();
  endtask

  // read strobe in the cycle right after the write
  task automatic write_then_read();
    haddr_t addr;
    hstrb_t strb;
    start_test("write_then_read");
    for (int i = 0; i < 4; i++) begin
      addr = haddr_t'($urandom);
      strb = (i == 3) ? 4'h6 : 4'hF;  // last one partial
      host_write(addr, hword_t'($urandom), strb);
      read_and_check(addr);
    end
    finish_test();
  endtask

  initial begin
    void'($urandom(56742));
    clk          = 1'b0;
    rst_i        = 1'b1;
    req          = '0;
    cur_test     = "none";
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);  // reset held for two edges
    #1;
    rst_i = 1'b0;

    reset_idle();
    full_word();
    byte_strobe();
    bank_mapping();
    back_to_back();
    write_then_read();

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== source/multibank_mem.sv ====
`timescale 1ns/1ps

// multi bank memory behind a single 32-bit host port
module multibank_mem #(
  parameter int RD_LATENCY = 1  // edges from read strobe to dack_o
) (
  input  logic                              clk,
  input  logic                              rst_i,
  input  mbank_pkg::host_req_t              req_i,
  output logic [mbank_pkg::HOST_DATA_W-1:0] rdata_o,
  output logic                              dack_o
);

  // translator to bank wiring
  mbank_pkg::bank_req_t                  bank_req   [mbank_pkg::BANK_COUNT];
  logic [mbank_pkg::BANK_DATA_W-1:0]     bank_rdata [mbank_pkg::BANK_COUNT];
  logic [mbank_pkg::BANK_COUNT-1:0]      bank_dack;  // one ack per bank

  // address split and read data steering
  bank_translator #(
    .RD_LATENCY (RD_LATENCY)
  ) i_bank_translator (
    .clk          (clk),
    .host_req_i   (req_i),
    .host_rdata_o (rdata_o),
    .host_dack_o  (dack_o),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata),
    .bank_dack_i  (bank_dack)
  );

  // the banks, all the same latency so acks line up
  for (genvar b = 0; b < mbank_pkg::BANK_COUNT; b++) begin : g_bank
    bram_bank #(
      .RD_LATENCY (RD_LATENCY)
    ) i_bram_bank (
      .clk     (clk),
      .rst_i   (rst_i),
      .req_i   (bank_req[b]),
      .rdata_o (bank_rdata[b]),
      .dack_o  (bank_dack[b])
    );
  end

endmodule

// ==== source/bank_translator.sv ====
`timescale 1ns/1ps

// host port to bank array translation
// each host word holds LANES bank words, lane i of word a lands in bank {a[0], i}
// at row a >> 1
module bank_translator #(
  parameter int RD_LATENCY = 1
) (
  input  logic                                 clk,

  // host side
  input  mbank_pkg::host_req_t                 host_req_i,
  output logic [mbank_pkg::HOST_DATA_W-1:0]    host_rdata_o,
  output logic                                 host_dack_o,

  // bank side
  output mbank_pkg::bank_req_t                 bank_req_o   [mbank_pkg::BANK_COUNT],
  input  logic [mbank_pkg::BANK_DATA_W-1:0]    bank_rdata_i [mbank_pkg::BANK_COUNT],
  input  logic [mbank_pkg::BANK_COUNT-1:0]     bank_dack_i
);

  localparam int LANES  = mbank_pkg::LANES;
  localparam int DW     = mbank_pkg::BANK_DATA_W;
  localparam int SW     = mbank_pkg::BANK_STRB_W;
  localparam int SEL_W  = mbank_pkg::BANK_SEL_W;
  localparam int ROW_W  = mbank_pkg::BANK_ADDR_W;
  localparam int LANE_W = $clog2(LANES);  // lane index bits appended to the address

  // internal address = host address with lane index below it
  // low SEL_W bits pick the bank, the next ROW_W bits are the row
  localparam int ITRL_W = mbank_pkg::HOST_ADDR_W + LANE_W;

  logic [ITRL_W-1:0]           itrl_addr [LANES];
  logic [SEL_W-1:0]            lane_bank [LANES];  // target bank per lane
  logic [ROW_W-1:0]            lane_row  [LANES];
  logic [DW-1:0]               lane_din  [LANES];
  logic [SW-1:0]               lane_strb [LANES];

  logic [mbank_pkg::BANK_COUNT-1:0] bank_hit;  // banks touched by this host word

  // bank numbers of reads in flight, stage 0 written at the request edge
  logic [SEL_W-1:0] sel_pipe [RD_LATENCY][LANES];

  // binary bank number to one-hot
  function automatic logic [mbank_pkg::BANK_COUNT-1:0] to_onehot(
    input logic [SEL_W-1:0] bank
  );
    logic [mbank_pkg::BANK_COUNT-1:0] oh;
    oh       = '0;
    oh[bank] = 1'b1;
    return oh;
  endfunction

  // split the host request into lanes
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      itrl_addr[l] = {host_req_i.addr, LANE_W'(l)};
      lane_bank[l] = itrl_addr[l][SEL_W-1:0];
      lane_row[l]  = itrl_addr[l][SEL_W +: ROW_W];
      lane_din[l]  = host_req_i.din[l*DW +: DW];       // lsb lane first
      lane_strb[l] = host_req_i.wrstrb[l*SW +: SW];
    end
  end

  // union of the one-hot selects of every lane
  always_comb begin
    bank_hit = '0;
    for (int l = 0; l < LANES; l++) begin
      bank_hit = bank_hit | to_onehot(lane_bank[l]);
    end
  end

  // per bank requests, no register in between
  // bank b only ever serves lane b % LANES, so it takes that lane's fields
  always_comb begin
    for (int b = 0; b < mbank_pkg::BANK_COUNT; b++) begin
      bank_req_o[b].rden   = host_req_i.rden & bank_hit[b];
      bank_req_o[b].wren   = host_req_i.wren & bank_hit[b];
      bank_req_o[b].wrstrb = lane_strb[b % LANES];
      bank_req_o[b].addr   = lane_row[b % LANES];
      bank_req_o[b].din    = lane_din[b % LANES];  // ignored unless wren
    end
  end

  // bank select pipeline, shifts every cycle
  // the entry at the last stage lines up with the bank read data
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      sel_pipe[0][l] <= lane_bank[l];
      for (int s = 1; s < RD_LATENCY; s++) begin
        sel_pipe[s][l] <= sel_pipe[s-1][l];
      end
    end
  end

  // steer returned bank words back into host lanes
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      host_rdata_o[l*DW +: DW] = bank_rdata_i[sel_pipe[RD_LATENCY-1][l]];
    end
  end

  // every bank of a read acks in the same cycle, any of them will do
  assign host_dack_o = |bank_dack_i;

endmodule

// ==== source/bram_bank.sv ====
`timescale 1ns/1ps

// single bank, byte writable, read data comes out RD_LATENCY edges after the strobe
module bram_bank #(
  parameter int RD_LATENCY = 1
) (
  input  logic                              clk,
  input  logic                              rst_i,
  input  mbank_pkg::bank_req_t              req_i,
  output logic [mbank_pkg::BANK_DATA_W-1:0] rdata_o,
  output logic                              dack_o
);

  localparam int DW = mbank_pkg::BANK_DATA_W;
  localparam int BW = mbank_pkg::BYTE_W;

  // storage, no reset on contents
  logic [DW-1:0] mem [mbank_pkg::BANK_DEPTH];

  // read path, stage 0 is the array output register
  logic [DW-1:0]         rd_pipe  [RD_LATENCY];
  logic [RD_LATENCY-1:0] vld_pipe;  // one bit per stage, tracks reads in flight

  // byte masked write
  always_ff @(posedge clk) begin
    if (req_i.wren) begin
      for (int k = 0; k < mbank_pkg::BANK_STRB_W; k++) begin
        if (req_i.wrstrb[k]) begin
          mem[req_i.addr][k*BW +: BW] <= req_i.din[k*BW +: BW];  // only strobed bytes
        end
      end
    end
  end

  // data pipeline, payload only
  always_ff @(posedge clk) begin
    if (req_i.rden) begin
      rd_pipe[0] <= mem[req_i.addr];  // old data if a write hits the same edge
    end
    for (int s = 1; s < RD_LATENCY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];  // extra latency stages
    end
  end

  // valid pipeline runs alongside the data
  always_ff @(posedge clk) begin
    if (rst_i) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= req_i.rden;
      for (int s = 1; s < RD_LATENCY; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  // outputs from the last stage
  assign rdata_o = rd_pipe[RD_LATENCY-1];
  assign dack_o  = vld_pipe[RD_LATENCY-1];  // one pulse per read

endmodule

// ==== source/mbank_pkg.sv ====
package mbank_pkg;

  // basic widths
  localparam int BYTE_W      = 8;
  localparam int HOST_DATA_W = 32;  // host word
  localparam int BANK_DATA_W = 16;  // one bank word = one lane

  // lanes per host word, stored lsb to msb
  localparam int LANES = HOST_DATA_W / BANK_DATA_W;

  // byte strobes
  localparam int HOST_STRB_W = HOST_DATA_W / BYTE_W;
  localparam int BANK_STRB_W = BANK_DATA_W / BYTE_W;

  // bank array geometry
  localparam int BANK_COUNT = 4;
  localparam int BANK_SEL_W = $clog2(BANK_COUNT);   // bank number width
  localparam int BANK_DEPTH = 256;                  // rows per bank
  localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);  // row address width

  // host words visible through the port
  localparam int HOST_DEPTH  = BANK_COUNT * BANK_DEPTH / LANES;
  localparam int HOST_ADDR_W = $clog2(HOST_DEPTH);

  // host side request, one cycle strobes
  typedef struct packed {
    logic                   rden;    // read strobe
    logic                   wren;    // write strobe
    logic [HOST_STRB_W-1:0] wrstrb;  // byte enables
    logic [HOST_ADDR_W-1:0] addr;    // word address
    logic [HOST_DATA_W-1:0] din;     // write data
  } host_req_t;

  // per bank request, produced by the translator
  typedef struct packed {
    logic                   rden;
    logic                   wren;
    logic [BANK_STRB_W-1:0] wrstrb;
    logic [BANK_ADDR_W-1:0] addr;    // row
    logic [BANK_DATA_W-1:0] din;
  } bank_req_t;

endpackage
